// File: Makefile
VERILATOR   ?= verilator
TOP         := tb_game_link
FILELIST    := game_link.f
OBJ_DIR     := obj_dir
LOG         := sim.log
BUILD_FLAGS := --binary --assert --top-module $(TOP) -Mdir $(OBJ_DIR)
LINT_FLAGS  := --lint-only -Wall --timing --assert --top-module $(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) -f $(FILELIST)

# the simulator status is not trusted, the log decides.
run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^Test passed$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: game_link.f
logic/game_link_pkg.sv
logic/event_capture.sv
logic/event_framer.sv
logic/uart_tx.sv
logic/game_link_top.sv
verification/game_link_sva.sv
verification/game_link_checker.sv
verification/tb_game_link.sv

// File: logic/event_capture.sv
`timescale 1ns/1ps
`default_nettype none

module event_capture #(
    parameter game_link_pkg::byte_t START_CODE = game_link_pkg::DEFAULT_START_CODE,
    parameter game_link_pkg::byte_t SCORE_CODE = game_link_pkg::DEFAULT_SCORE_CODE
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 game_started,
    input  logic                 score_valid,
    input  game_link_pkg::byte_t score,
    input  logic                 req_taken,
    output logic                 req_valid,
    output game_link_pkg::byte_t req_code,
    output game_link_pkg::byte_t req_payload
);

    import game_link_pkg::*;

    logic  start_pending;
    logic  score_pending;
    byte_t start_payload;
    byte_t score_payload;
    logic  take_start;
    logic  take_score;

    // ====================================================================
    // which kind is being taken
    // ====================================================================

    // the start request is presented whenever it is pending, so req_taken
    // always refers to start first and to score only when start is clear.
    assign take_start = req_taken && start_pending;
    assign take_score = req_taken && !start_pending && score_pending;

    // ====================================================================
    // pending flags
    // ====================================================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            start_pending <= 1'b0;
            score_pending <= 1'b0;
        end else begin
            // a new strobe wins over the clear of its own kind.
            if (start) begin
                start_pending <= 1'b1;
            end else if (take_start) begin
                start_pending <= 1'b0;
            end

            if (score_valid) begin
                score_pending <= 1'b1;
            end else if (take_score) begin
                score_pending <= 1'b0;
            end
        end
    end

    // payloads are overwritten by every strobe, so the latest value wins.
    always_ff @(posedge clk) begin
        if (start) begin
            start_payload <= {7'b0000000, game_started};
        end
        if (score_valid) begin
            score_payload <= score;
        end
    end

    // ====================================================================
    // request presented to the framer
    // ====================================================================
    assign req_valid   = start_pending || score_pending;
    assign req_code    = start_pending ? START_CODE : SCORE_CODE;
    assign req_payload = start_pending ? start_payload : score_payload;

endmodule

`default_nettype wire

// File: logic/event_framer.sv
`timescale 1ns/1ps
`default_nettype none

module event_framer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 req_valid,
    input  game_link_pkg::byte_t req_code,
    input  game_link_pkg::byte_t req_payload,
    output logic                 req_taken,
    input  logic                 tx_busy,
    output game_link_pkg::byte_t tx_data,
    output logic                 tx_load,
    output logic                 data_sent
);

    import game_link_pkg::*;

    framer_state_t state;
    byte_t         payload_q;

    // ====================================================================
    // frame sequencer
    // ====================================================================

    // req_taken, tx_load and data_sent are registered one-cycle pulses.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= ST_IDLE;
            req_taken <= 1'b0;
            tx_load   <= 1'b0;
            data_sent <= 1'b0;
        end else begin
            req_taken <= 1'b0;
            tx_load   <= 1'b0;
            data_sent <= 1'b0;

            case (state)
                ST_IDLE: begin
                    if (req_valid) begin
                        req_taken <= 1'b1;  // capture clears the request on the next clock.
                        state     <= ST_LOAD_CODE;
                    end
                end

                ST_LOAD_CODE: begin
                    if (!tx_busy) begin
                        tx_load <= 1'b1;
                        state   <= ST_SEND_CODE;
                    end
                end

                // tx_busy rises on the clock after tx_load.
                ST_SEND_CODE: begin
                    if (tx_busy) begin
                        state <= ST_LOAD_PAYLOAD;
                    end
                end

                ST_LOAD_PAYLOAD: begin
                    if (!tx_busy) begin
                        tx_load <= 1'b1;
                        state   <= ST_SEND_PAYLOAD;
                    end
                end

                ST_SEND_PAYLOAD: begin
                    if (tx_busy) begin
                        state <= ST_DONE;
                    end
                end

                ST_DONE: begin
                    if (!tx_busy) begin
                        data_sent <= 1'b1;  // stop bit of the payload byte has ended.
                        state     <= ST_IDLE;
                    end
                end

                default: state <= ST_IDLE;
            endcase
        end
    end

    // ====================================================================
    // byte registers
    // ====================================================================

    // the request is copied in the req_taken cycle, before capture moves on.
    always_ff @(posedge clk) begin
        if (req_taken) begin
            tx_data   <= req_code;
            payload_q <= req_payload;
        end else if (state == ST_LOAD_PAYLOAD && !tx_busy) begin
            tx_data <= payload_q;
        end
    end

endmodule

`default_nettype wire

// File: logic/game_link_pkg.sv
`default_nettype none

package game_link_pkg;

    // ====================================================================
    // common types
    // ====================================================================

    // one byte on the serial line. also used for payloads, scores and codes.
    typedef logic [7:0] byte_t;

    // framer sequence for one two-byte frame.
    typedef enum logic [2:0] {
        ST_IDLE,          // waiting for a pending request.
        ST_LOAD_CODE,     // request taken, code byte goes out when the line is free.
        ST_SEND_CODE,     // code byte handed over, waiting for the transmitter to start.
        ST_LOAD_PAYLOAD,  // waiting for the code byte to finish.
        ST_SEND_PAYLOAD,  // payload byte handed over.
        ST_DONE           // waiting for the payload byte to finish.
    } framer_state_t;

    // ====================================================================
    // default event codes
    // ====================================================================
    localparam byte_t DEFAULT_START_CODE = 8'hAA;
    localparam byte_t DEFAULT_SCORE_CODE = 8'h5C;

endpackage

`default_nettype wire

// File: logic/game_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module game_link_top #(
    parameter game_link_pkg::byte_t START_CODE   = game_link_pkg::DEFAULT_START_CODE,
    parameter game_link_pkg::byte_t SCORE_CODE   = game_link_pkg::DEFAULT_SCORE_CODE,
    parameter int                   CLKS_PER_BIT = 434
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 start,
    input  logic                 game_started,
    input  logic                 score_valid,
    input  game_link_pkg::byte_t score,
    output logic                 tx,
    output logic                 data_sent
);

    import game_link_pkg::*;

    logic  req_valid;
    logic  req_taken;
    byte_t req_code;
    byte_t req_payload;
    logic  tx_load;
    logic  tx_busy;
    byte_t tx_data;

    // ====================================================================
    // capture, framer and transmitter
    // ====================================================================
    event_capture #(
        .START_CODE (START_CODE),
        .SCORE_CODE (SCORE_CODE)
    ) u_capture (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .game_started (game_started),
        .score_valid  (score_valid),
        .score        (score),
        .req_taken    (req_taken),
        .req_valid    (req_valid),
        .req_code     (req_code),
        .req_payload  (req_payload)
    );

    event_framer u_framer (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (req_valid),
        .req_code    (req_code),
        .req_payload (req_payload),
        .req_taken   (req_taken),
        .tx_busy     (tx_busy),
        .tx_data     (tx_data),
        .tx_load     (tx_load),
        .data_sent   (data_sent)
    );

    uart_tx #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_uart_tx (
        .clk     (clk),
        .reset   (reset),
        .tx_data (tx_data),
        .tx_load (tx_load),
        .tx_busy (tx_busy),
        .tx      (tx)
    );

endmodule

`default_nettype wire

// File: logic/uart_tx.sv
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
    parameter int CLKS_PER_BIT = 434
) (
    input  logic                 clk,
    input  logic                 reset,
    input  game_link_pkg::byte_t tx_data,
    input  logic                 tx_load,
    output logic                 tx_busy,
    output logic                 tx
);

    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] LAST_CLK = CNT_W'(CLKS_PER_BIT - 1);
    localparam logic [3:0]       LAST_BIT = 4'd9;  // start, eight data bits, stop.

    logic [9:0]       frame_q;  // shifted out from bit 0.
    logic [CNT_W-1:0] clk_cnt;
    logic [3:0]       bit_cnt;
    logic             busy_q;

    // ====================================================================
    // serializer
    // ====================================================================

    // the frame register idles at all ones so the line stays high.
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            frame_q <= '1;
            clk_cnt <= '0;
            bit_cnt <= '0;
            busy_q  <= 1'b0;
        end else if (!busy_q) begin
            if (tx_load) begin
                frame_q <= {1'b1, tx_data, 1'b0};  // stop, data lsb first, start.
                clk_cnt <= '0;
                bit_cnt <= '0;
                busy_q  <= 1'b1;
            end
        end else if (clk_cnt == LAST_CLK) begin
            clk_cnt <= '0;
            frame_q <= {1'b1, frame_q[9:1]};
            if (bit_cnt == LAST_BIT) begin
                bit_cnt <= '0;
                busy_q  <= 1'b0;  // stop bit has been held for a full bit time.
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end else begin
            clk_cnt <= clk_cnt + 1'b1;
        end
    end

    assign tx      = frame_q[0];
    assign tx_busy = busy_q;

endmodule

`default_nettype wire

// File: verification/game_link_checker.sv
`timescale 1ns/1ps
`default_nettype none

module game_link_checker #(
    parameter game_link_pkg::byte_t START_CODE   = game_link_pkg::DEFAULT_START_CODE,
    parameter game_link_pkg::byte_t SCORE_CODE   = game_link_pkg::DEFAULT_SCORE_CODE,
    parameter int                   CLKS_PER_BIT = 8
) (
    input logic                 clk,
    input logic                 reset,
    input logic                 start,
    input logic                 game_started,
    input logic                 score_valid,
    input game_link_pkg::byte_t score,
    input logic                 tx,
    input logic                 data_sent
);

    import game_link_pkg::*;

    localparam int SENT_LIMIT = 4 * CLKS_PER_BIT;

    logic  start_pend;   // reference model, one pending entry per kind.
    logic  score_pend;
    byte_t start_val;
    byte_t score_val;
    logic  frame_known;
    byte_t exp_code;
    byte_t exp_payload;
    logic  rx_busy;
    int    phase;        // clocks since the start bit was seen.
    int    bit_idx;
    int    byte_idx;
    byte_t rx_byte;
    int    sent_wait;    // -1 while no data_sent is due.

    int    errors = 0;
    int    frames = 0;
    int    frames_started = 0;
    int    sent_count = 0;
    int    tests_run = 0;
    int    tests_failed = 0;
    int    err_base = 0;
    string cur_name = "none";

    task automatic report(input string what);
        errors++;
        $display("ERROR in %s: %s", cur_name, what);
    endtask

    task automatic compare_byte(input string what, input byte_t expected, input byte_t actual);
        if (frame_known && expected !== actual) begin
            errors++;
            $display("[FAIL] %s: %s expected %02h, actual %02h",
                     cur_name, what, expected, actual);
        end
    endtask

    // the pending kind with priority leaves the model when its start bit shows.
    task automatic take_request();
        frame_known = 1'b1;
        frames_started++;
        if (start_pend) begin
            exp_code    = START_CODE;
            exp_payload = start_val;
            start_pend  = 1'b0;
        end else if (score_pend) begin
            exp_code    = SCORE_CODE;
            exp_payload = score_val;
            score_pend  = 1'b0;
        end else begin
            frame_known = 1'b0;
            report("start bit on tx with no pending event");
        end
    endtask

    task automatic finish_byte();
        if (byte_idx == 0) begin
            compare_byte("code byte", exp_code, rx_byte);
            byte_idx = 1;
        end else begin
            compare_byte("payload byte", exp_payload, rx_byte);
            byte_idx  = 0;
            frames++;
            sent_wait = 0;
        end
    endtask

    task automatic begin_test(input string name);
        cur_name = name;
        err_base = errors;
    endtask

    task automatic end_test(input logic timed_out);
        tests_run++;
        if (timed_out || errors != err_base) begin
            tests_failed++;
            $display("test %s: FAILED with %0d error(s)", cur_name, errors - err_base);
        end else begin
            $display("test %s: ok", cur_name);
        end
    endtask

    // ====================================================================
    // line decoder and model update
    // ====================================================================
    always @(posedge clk or posedge reset) begin
        if (reset) begin
            start_pend  = 1'b0;
            score_pend  = 1'b0;
            frame_known = 1'b0;
            rx_busy     = 1'b0;
            phase       = 0;
            byte_idx    = 0;
            sent_wait   = -1;
        end else begin
            if (data_sent) begin
                if (sent_wait < 0) report("data_sent pulse without a finished frame");
                sent_count++;
                sent_wait = -1;
            end else if (sent_wait >= 0) begin
                sent_wait++;
                if (sent_wait > SENT_LIMIT) begin
                    report("no data_sent pulse after the payload byte");
                    sent_wait = -1;
                end
            end

            if (rx_busy) begin
                phase++;
                if (phase % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin  // middle of a bit.
                    bit_idx = phase / CLKS_PER_BIT;
                    if (bit_idx == 0) begin
                        if (tx !== 1'b0) report("start bit did not stay low");
                    end else if (bit_idx <= 8) begin
                        rx_byte[bit_idx - 1] = tx;
                    end else begin
                        if (tx !== 1'b1) report("stop bit is low");
                        rx_busy = 1'b0;
                        finish_byte();
                    end
                end
            end else if (tx !== 1'b1) begin
                rx_busy = 1'b1;
                phase   = 0;
                if (byte_idx == 0) take_request();
            end

            // a strobe of a kind already pending overwrites it in place.
            if (start) begin
                start_pend = 1'b1;
                start_val  = {7'b0000000, game_started};
            end
            if (score_valid) begin
                score_pend = 1'b1;
                score_val  = score;
            end
        end
    end

endmodule

`default_nettype wire

// File: verification/game_link_sva.sv
`timescale 1ns/1ps
`default_nettype none

module game_link_sva (
    input logic                         clk,
    input logic                         reset,
    input game_link_pkg::framer_state_t state,
    input logic                         req_valid,
    input logic                         req_taken,
    input logic                         tx_busy,
    input logic                         tx_load,
    input logic                         data_sent
);

    import game_link_pkg::*;

    int fail_count = 0;  // failed assertions so far.

    // the transmitter only takes a byte while it is free.
    load_when_free: assert property (@(posedge clk) disable iff (reset)
        tx_load |-> !tx_busy)
        else begin
            $error("tx_load raised while tx_busy is high");
            fail_count++;
        end

    sent_is_pulse: assert property (@(posedge clk) disable iff (reset)
        data_sent |=> !data_sent)
        else begin
            $error("data_sent held for more than one cycle");
            fail_count++;
        end

    // req_taken is registered, so it follows the idle cycle that saw the request.
    taken_from_idle: assert property (@(posedge clk) disable iff (reset)
        req_taken |-> ($past(state) == ST_IDLE && $past(req_valid)))
        else begin
            $error("req_taken without a request seen in idle");
            fail_count++;
        end

endmodule

`default_nettype wire

// File: verification/tb_game_link.sv
`timescale 1ns/1ps
`default_nettype none

module tb_game_link;

    import game_link_pkg::*;

    localparam int CLKS_PER_BIT  = 8;
    localparam int FRAME_CYCLES  = 24 * CLKS_PER_BIT;  // one frame plus slack.
    localparam int RANDOM_EVENTS = 24;

    logic   clk = 1'b0;
    logic   reset;
    logic   start;
    logic   game_started;
    logic   score_valid;
    byte_t  score;
    logic   tx;
    logic   data_sent;
    integer seed;
    logic   timed_out;
    int     timeouts = 0;
    int     base;

    always #10 clk = ~clk;

    game_link_top #(
        .START_CODE   (DEFAULT_START_CODE),
        .SCORE_CODE   (DEFAULT_SCORE_CODE),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) DUT (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .game_started (game_started),
        .score_valid  (score_valid),
        .score        (score),
        .tx           (tx),
        .data_sent    (data_sent)
    );

    game_link_checker #(
        .START_CODE   (DEFAULT_START_CODE),
        .SCORE_CODE   (DEFAULT_SCORE_CODE),
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) watch (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .game_started (game_started),
        .score_valid  (score_valid),
        .score        (score),
        .tx           (tx),
        .data_sent    (data_sent)
    );

    bind event_framer game_link_sva framer_sva (
        .clk       (clk),
        .reset     (reset),
        .state     (state),
        .req_valid (req_valid),
        .req_taken (req_taken),
        .tx_busy   (tx_busy),
        .tx_load   (tx_load),
        .data_sent (data_sent)
    );

    // ====================================================================
    // stimulus helpers, all called on a falling edge
    // ====================================================================
    function automatic byte_t rand_byte();
        return byte_t'($random(seed));
    endfunction

    task automatic strobe(input logic do_start, input logic level,
                          input logic do_score, input byte_t value);
        start        = do_start;
        game_started = level;
        score_valid  = do_score;
        score        = value;
        @(negedge clk);
        start       = 1'b0;
        score_valid = 1'b0;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // counts either frame starts or data_sent pulses seen by the checker.
    task automatic wait_count(input int target, input logic use_sent, input int limit,
                              input string what);
        int waited;
        int seen;
        waited = 0;
        seen   = use_sent ? watch.sent_count : watch.frames_started;
        while (seen < target && waited < limit) begin
            @(negedge clk);
            waited++;
            seen = use_sent ? watch.sent_count : watch.frames_started;
        end
        if (seen < target) begin
            $display("timeout: no %s within %0d cycles", what, limit);
            timed_out = 1'b1;
            timeouts++;
        end
    endtask

    task automatic open_test(input string name);
        watch.begin_test(name);
        timed_out = 1'b0;
        base      = watch.sent_count;
    endtask

    task automatic close_test();
        idle_cycles(4 * CLKS_PER_BIT);  // room for a stray extra frame to show up.
        watch.end_test(timed_out);
    endtask

    // ====================================================================
    // test sequence
    // ====================================================================
    initial begin
        byte_t rnd;
        byte_t first_score;
        int    started;
        int    sva_fails;
        seed         = 77;
        reset        = 1'b1;
        start        = 1'b0;
        game_started = 1'b0;
        score_valid  = 1'b0;
        score        = '0;
        timed_out    = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        open_test("reset_idle");
        idle_cycles(100);
        close_test();

        open_test("start_frame");
        rnd = rand_byte();
        strobe(1'b1, rnd[0], 1'b0, 8'h00);
        wait_count(base + 1, 1'b1, FRAME_CYCLES, "data_sent pulse");
        close_test();

        open_test("score_frame");
        strobe(1'b0, 1'b0, 1'b1, rand_byte());
        wait_count(base + 1, 1'b1, FRAME_CYCLES, "data_sent pulse");
        close_test();

        open_test("same_cycle");
        rnd = rand_byte();
        strobe(1'b1, rnd[0], 1'b1, rand_byte());
        wait_count(base + 2, 1'b1, 2 * FRAME_CYCLES, "second data_sent pulse");
        close_test();

        open_test("score_overwrite");
        rnd         = rand_byte();
        first_score = rand_byte();
        strobe(1'b1, rnd[0], 1'b0, 8'h00);
        idle_cycles(2);
        strobe(1'b0, 1'b0, 1'b1, first_score);
        idle_cycles(3);
        strobe(1'b0, 1'b0, 1'b1, first_score ^ (rand_byte() | 8'h01));
        wait_count(base + 2, 1'b1, 2 * FRAME_CYCLES, "second data_sent pulse");
        close_test();

        open_test("random_sequence");
        for (int i = 0; i < RANDOM_EVENTS; i++) begin
            started = watch.frames_started + 1;
            idle_cycles($random(seed) & 63);
            rnd = rand_byte();
            if (rnd[7]) begin
                strobe(1'b1, rnd[0], 1'b0, 8'h00);
            end else begin
                strobe(1'b0, 1'b0, 1'b1, rand_byte());
            end
            wait_count(started, 1'b0, 2 * FRAME_CYCLES, "start bit on tx");
        end
        wait_count(base + RANDOM_EVENTS, 1'b1, 2 * FRAME_CYCLES, "final data_sent pulse");
        idle_cycles(FRAME_CYCLES);
        close_test();

        sva_fails = DUT.u_framer.framer_sva.fail_count;
        $display("tests %0d, failed %0d, frames %0d, sent %0d, errors %0d, timeouts %0d, sva %0d",
                 watch.tests_run, watch.tests_failed, watch.frames, watch.sent_count,
                 watch.errors, timeouts, sva_fails);
        if (watch.tests_failed == 0 && watch.errors == 0 && timeouts == 0 && sva_fails == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
